// ==== hdl/mem_op_pkg.sv ====
package mem_op_pkg;

    localparam int DATA_W          = 32;
    localparam int ADDR_W          = 32;
    localparam int REG_ADDR_W      = 5;
    localparam int SRAM_DEPTH_LOG2 = 8;

    // read length codes seen by the SRAM side of the access unit.
    localparam logic [1:0] RLEN_BYTE = 2'd0;
    localparam logic [1:0] RLEN_HALF = 2'd1;
    localparam logic [1:0] RLEN_WORD = 2'd2;

    typedef enum logic [5:0] {
        OP_NONE = 6'd0,
        OP_LW,
        OP_LL,
        OP_LH,
        OP_LHU,
        OP_LB,
        OP_LBU,
        OP_LWL,
        OP_LWR,
        OP_SW,
        OP_SWL,
        OP_SWR,
        OP_SC,
        OP_SH,
        OP_SB
    } mem_op_t;

    // true for every opcode that returns a value to the register file.
    function automatic logic is_load_op(mem_op_t op);
        case (op)
            OP_LW, OP_LL, OP_LH, OP_LHU, OP_LB, OP_LBU, OP_LWL, OP_LWR: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

endpackage

// ==== hdl/except_pkg.sv ====
package except_pkg;

    localparam int EXC_W = 8;

    // one bit per cause; any set bit marks the instruction as faulting.
    typedef logic [EXC_W-1:0] except_bus;

    // address error on load or instruction fetch.
    localparam int EXC_ADEL = 0;
    // address error on store.
    localparam int EXC_ADES = 1;
    localparam int EXC_TLB  = 2;
    // interrupt taken on this instruction.
    localparam int EXC_INT  = 3;

endpackage

// ==== hdl/mem_issue_stage.sv ====
`timescale 1ns/100ps

module mem_issue_stage (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              flush,
    input  logic                              req_valid,
    input  mem_op_pkg::mem_op_t               req_op,
    input  logic [mem_op_pkg::ADDR_W-1:0]     req_addr,
    input  logic [mem_op_pkg::DATA_W-1:0]     req_wdata,
    input  logic [mem_op_pkg::REG_ADDR_W-1:0] req_rd,
    input  logic                              master_mem_sel,
    input  logic                              slave_mem_sel,
    input  except_pkg::except_bus             master_except,
    input  except_pkg::except_bus             slave_except,
    output logic                              iss_valid,
    output mem_op_pkg::mem_op_t               iss_op,
    output logic [mem_op_pkg::ADDR_W-1:0]     iss_addr,
    output logic [mem_op_pkg::DATA_W-1:0]     iss_wdata,
    output logic [mem_op_pkg::REG_ADDR_W-1:0] iss_rd,
    output logic                              iss_master_sel,
    output logic                              iss_slave_sel,
    output except_pkg::except_bus             iss_master_except,
    output except_pkg::except_bus             iss_slave_except
);
    import mem_op_pkg::*;

    logic take;

    // a flush in the same cycle kills the request before it is captured.
    assign take = req_valid && !flush;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            iss_valid         <= 1'b0;
            iss_op            <= OP_NONE;
            iss_master_sel    <= 1'b0;
            iss_slave_sel     <= 1'b0;
            iss_master_except <= '0;
            iss_slave_except  <= '0;
        end else begin
            iss_valid         <= take;
            iss_op            <= take ? req_op : OP_NONE;
            iss_master_sel    <= take && master_mem_sel;
            iss_slave_sel     <= take && slave_mem_sel;
            iss_master_except <= take ? master_except : '0;
            iss_slave_except  <= take ? slave_except : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            iss_addr  <= req_addr;
            iss_wdata <= req_wdata;
            iss_rd    <= req_rd;
        end
    end

    // only one issue lane may own the memory port at a time.
    sel_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        iss_valid |-> !(iss_master_sel && iss_slave_sel))
        else $error("both lane selects high on a valid memory request");

endmodule

// ==== hdl/mem_access.sv ====
`timescale 1ns/100ps

module mem_access (
    input  logic                          mem_en,
    input  mem_op_pkg::mem_op_t           mem_op,
    input  logic [mem_op_pkg::ADDR_W-1:0] mem_addr,
    input  logic [mem_op_pkg::DATA_W-1:0] mem_wdata,
    input  logic                          M_master_mem_sel,
    input  logic                          M_slave_mem_sel,
    input  except_pkg::except_bus         M_master_except,
    input  except_pkg::except_bus         M_slave_except,
    input  logic [mem_op_pkg::DATA_W-1:0] data_sram_rdata,
    output logic [mem_op_pkg::DATA_W-1:0] mem_rdata,
    output logic                          data_sram_en,
    output logic [1:0]                    data_sram_rlen,
    output logic [3:0]                    data_sram_wen,
    output logic [mem_op_pkg::ADDR_W-1:0] data_sram_addr,
    output logic [mem_op_pkg::DATA_W-1:0] data_sram_wdata
);
    import mem_op_pkg::*;

    logic [1:0]        off;
    logic [4:0]        lo_shift;
    logic [4:0]        hi_shift;
    logic [7:0]        rd_byte;
    logic [15:0]       rd_half;
    logic              half_ok;
    logic              master_ok;
    logic              slave_ok;
    logic [DATA_W-1:0] keep_lwl;
    logic [DATA_W-1:0] keep_lwr;

    // a master fault also blocks the slave, since the slave is younger.
    assign master_ok    = M_master_mem_sel && !(|M_master_except);
    assign slave_ok     = M_slave_mem_sel && !(|M_master_except) && !(|M_slave_except);
    assign data_sram_en = mem_en && (master_ok || slave_ok);

    assign data_sram_addr = mem_addr;

    assign off      = mem_addr[1:0];
    assign lo_shift = {off, 3'b000};
    assign hi_shift = {~off, 3'b000};

    assign rd_byte = data_sram_rdata[lo_shift +: 8];
    assign rd_half = off[1] ? data_sram_rdata[31:16] : data_sram_rdata[15:0];
    // halfword loads at odd offsets return zero.
    assign half_ok = !off[0];

    // register bytes that LWL and LWR leave untouched.
    assign keep_lwl = 32'h00ff_ffff >> lo_shift;
    assign keep_lwr = ~(32'hffff_ffff >> lo_shift);

    always_comb begin
        data_sram_wen   = 4'b0000;
        data_sram_wdata = '0;
        data_sram_rlen  = RLEN_BYTE;
        mem_rdata       = '0;
        case (mem_op)
            OP_LW, OP_LL: begin
                data_sram_rlen = RLEN_WORD;
                mem_rdata      = data_sram_rdata;
            end
            OP_LH: begin
                data_sram_rlen = RLEN_HALF;
                if (half_ok) begin
                    mem_rdata = {{16{rd_half[15]}}, rd_half};
                end
            end
            OP_LHU: begin
                data_sram_rlen = RLEN_HALF;
                if (half_ok) begin
                    mem_rdata = {16'h0000, rd_half};
                end
            end
            OP_LB: begin
                data_sram_rlen = RLEN_BYTE;
                mem_rdata      = {{24{rd_byte[7]}}, rd_byte};
            end
            OP_LBU: begin
                data_sram_rlen = RLEN_BYTE;
                mem_rdata      = {24'h00_0000, rd_byte};
            end
            OP_LWL: begin
                mem_rdata = (data_sram_rdata << hi_shift) | (mem_wdata & keep_lwl);
            end
            OP_LWR: begin
                mem_rdata = (data_sram_rdata >> lo_shift) | (mem_wdata & keep_lwr);
            end
            OP_SW, OP_SC: begin
                // misaligned word stores are dropped.
                data_sram_wen   = (off == 2'b00) ? 4'b1111 : 4'b0000;
                data_sram_wdata = mem_wdata;
            end
            OP_SWL: begin
                data_sram_wen   = 4'b1111 >> (~off);
                data_sram_wdata = mem_wdata >> hi_shift;
            end
            OP_SWR: begin
                data_sram_wen   = 4'b1111 << off;
                data_sram_wdata = mem_wdata << lo_shift;
            end
            OP_SH: begin
                case (off)
                    2'b00:   data_sram_wen = 4'b0011;
                    2'b10:   data_sram_wen = 4'b1100;
                    default: data_sram_wen = 4'b0000;
                endcase
                data_sram_wdata = {2{mem_wdata[15:0]}};
            end
            OP_SB: begin
                data_sram_wen   = 4'b0001 << off;
                data_sram_wdata = {4{mem_wdata[7:0]}};
            end
            default: begin
                data_sram_wen = 4'b0000;
            end
        endcase
    end

    load_no_write: assert final (!is_load_op(mem_op) || data_sram_wen == 4'b0000)
        else $error("load opcode %s drives SRAM write enables", mem_op.name());

endmodule

// ==== hdl/data_sram.sv ====
`timescale 1ns/100ps

module data_sram (
    input  logic                          clk,
    input  logic                          en,
    input  logic [3:0]                    wen,
    input  logic [mem_op_pkg::ADDR_W-1:0] addr,
    input  logic [mem_op_pkg::DATA_W-1:0] wdata,
    output logic [mem_op_pkg::DATA_W-1:0] rdata
);
    import mem_op_pkg::*;

    localparam int DEPTH = 2 ** SRAM_DEPTH_LOG2;

    logic [DATA_W-1:0]          mem [DEPTH];
    logic [SRAM_DEPTH_LOG2-1:0] word_idx;

    // byte address bits below the word are ignored; lanes come from wen.
    assign word_idx = addr[SRAM_DEPTH_LOG2+1:2];

    always_ff @(posedge clk) begin
        if (en) begin
            for (int b = 0; b < 4; b++) begin
                if (wen[b]) begin
                    mem[word_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // asynchronous read so a load sees data in its own cycle.
    assign rdata = mem[word_idx];

endmodule

// ==== hdl/wb_stage.sv ====
`timescale 1ns/100ps

module wb_stage (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              iss_valid,
    input  mem_op_pkg::mem_op_t               iss_op,
    input  logic [mem_op_pkg::REG_ADDR_W-1:0] iss_rd,
    input  logic [mem_op_pkg::DATA_W-1:0]     mem_rdata,
    input  except_pkg::except_bus             iss_master_except,
    input  except_pkg::except_bus             iss_slave_except,
    output logic                              wb_we,
    output logic [mem_op_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [mem_op_pkg::DATA_W-1:0]     wb_data,
    output except_pkg::except_bus             wb_except,
    output logic                              wb_fault
);
    import mem_op_pkg::*;
    import except_pkg::*;

    except_bus lane_exc;
    logic      fault;
    logic      load_ok;

    assign lane_exc = iss_master_except | iss_slave_except;
    assign fault    = iss_valid && (|lane_exc);

    // register 0 is hardwired, so a load to it never writes back.
    assign load_ok = iss_valid && is_load_op(iss_op) && !fault && (iss_rd != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_we     <= 1'b0;
            wb_rd     <= '0;
            wb_data   <= '0;
            wb_except <= '0;
            wb_fault  <= 1'b0;
        end else begin
            wb_we     <= load_ok;
            wb_data   <= load_ok ? mem_rdata : '0;
            wb_except <= iss_valid ? lane_exc : '0;
            wb_fault  <= fault;
            if (iss_valid) begin
                wb_rd <= iss_rd;
            end
        end
    end

endmodule

// ==== hdl/mem_subsys_top.sv ====
`timescale 1ns/100ps

module mem_subsys_top (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              req_valid,
    input  mem_op_pkg::mem_op_t               req_op,
    input  logic [mem_op_pkg::ADDR_W-1:0]     req_addr,
    input  logic [mem_op_pkg::DATA_W-1:0]     req_wdata,
    input  logic [mem_op_pkg::REG_ADDR_W-1:0] req_rd,
    input  logic                              master_mem_sel,
    input  logic                              slave_mem_sel,
    input  except_pkg::except_bus             master_except,
    input  except_pkg::except_bus             slave_except,
    input  logic                              flush,
    output logic                              wb_we,
    output logic [mem_op_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [mem_op_pkg::DATA_W-1:0]     wb_data,
    output except_pkg::except_bus             wb_except,
    output logic                              wb_fault
);
    import mem_op_pkg::*;
    import except_pkg::*;

    logic                  iss_valid;
    mem_op_t               iss_op;
    logic [ADDR_W-1:0]     iss_addr;
    logic [DATA_W-1:0]     iss_wdata;
    logic [REG_ADDR_W-1:0] iss_rd;
    logic                  iss_master_sel;
    logic                  iss_slave_sel;
    except_bus             iss_master_except;
    except_bus             iss_slave_except;

    logic                  data_sram_en;
    logic [3:0]            data_sram_wen;
    logic [ADDR_W-1:0]     data_sram_addr;
    logic [DATA_W-1:0]     data_sram_wdata;
    logic [DATA_W-1:0]     data_sram_rdata;
    logic [DATA_W-1:0]     mem_rdata;

    mem_issue_stage u_issue (
        .clk, .arst_n, .flush, .req_valid, .req_op, .req_addr, .req_wdata, .req_rd,
        .master_mem_sel, .slave_mem_sel, .master_except, .slave_except,
        .iss_valid, .iss_op, .iss_addr, .iss_wdata, .iss_rd,
        .iss_master_sel, .iss_slave_sel, .iss_master_except, .iss_slave_except
    );

    // the local SRAM always returns a full word, so the read length stays open.
    mem_access u_access (
        .mem_en           (iss_valid),
        .mem_op           (iss_op),
        .mem_addr         (iss_addr),
        .mem_wdata        (iss_wdata),
        .M_master_mem_sel (iss_master_sel),
        .M_slave_mem_sel  (iss_slave_sel),
        .M_master_except  (iss_master_except),
        .M_slave_except   (iss_slave_except),
        .data_sram_rdata, .mem_rdata, .data_sram_en, .data_sram_rlen (),
        .data_sram_wen, .data_sram_addr, .data_sram_wdata
    );

    data_sram u_sram (
        .clk, .en (data_sram_en), .wen (data_sram_wen), .addr (data_sram_addr),
        .wdata (data_sram_wdata), .rdata (data_sram_rdata)
    );

    wb_stage u_wb (
        .clk, .arst_n, .iss_valid, .iss_op, .iss_rd, .mem_rdata,
        .iss_master_except, .iss_slave_except,
        .wb_we, .wb_rd, .wb_data, .wb_except, .wb_fault
    );

endmodule

// ==== tests/tb_mem_subsys.sv ====
`timescale 1ns/100ps

module tb_mem_subsys;
    import mem_op_pkg::*;
    import except_pkg::*;

    localparam int FIELDS  = 12;
    localparam int MAX_VEC = 128;

    logic                  clk;
    logic                  arst_n;
    logic                  req_valid;
    mem_op_t               req_op;
    logic [ADDR_W-1:0]     req_addr;
    logic [DATA_W-1:0]     req_wdata;
    logic [REG_ADDR_W-1:0] req_rd;
    logic                  master_mem_sel;
    logic                  slave_mem_sel;
    except_bus             master_except;
    except_bus             slave_except;
    logic                  flush;
    logic                  wb_we;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [DATA_W-1:0]     wb_data;
    except_bus             wb_except;
    logic                  wb_fault;

    logic [31:0] vec_mem [FIELDS*MAX_VEC];

    // slot 0 holds the request driven last, slot 1 the one whose result is visible now.
    logic                  pend_we    [2];
    logic [DATA_W-1:0]     pend_data  [2];
    logic                  pend_fault [2];
    logic [REG_ADDR_W-1:0] pend_rd    [2];
    except_bus             pend_exc   [2];

    int checks = 0;
    int errors = 0;

    mem_subsys_top DUT (
        .clk, .arst_n, .req_valid, .req_op, .req_addr, .req_wdata, .req_rd,
        .master_mem_sel, .slave_mem_sel, .master_except, .slave_except, .flush,
        .wb_we, .wb_rd, .wb_data, .wb_except, .wb_fault
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic check_outputs();
        check_value("wb_we", 32'(wb_we), 32'(pend_we[1]));
        check_value("wb_data", wb_data, pend_data[1]);
        check_value("wb_fault", 32'(wb_fault), 32'(pend_fault[1]));
        check_value("wb_except", 32'(wb_except), 32'(pend_exc[1]));
        if (pend_we[1]) begin
            check_value("wb_rd", 32'(wb_rd), 32'(pend_rd[1]));
        end
    endtask

    task automatic drive_idle();
        req_valid      = 1'b0;
        req_op         = OP_NONE;
        req_addr       = '0;
        req_wdata      = '0;
        req_rd         = '0;
        master_mem_sel = 1'b0;
        slave_mem_sel  = 1'b0;
        master_except  = '0;
        slave_except   = '0;
        flush          = 1'b0;
        pend_we[0]     = 1'b0;
        pend_data[0]   = '0;
        pend_fault[0]  = 1'b0;
        pend_rd[0]     = '0;
        pend_exc[0]    = '0;
    endtask

    task automatic drive_vector(input int base);
        req_valid      = 1'b1;
        req_op         = mem_op_t'(vec_mem[base][5:0]);
        req_addr       = vec_mem[base+1];
        req_wdata      = vec_mem[base+2];
        req_rd         = vec_mem[base+3][REG_ADDR_W-1:0];
        master_mem_sel = vec_mem[base+4][1];
        slave_mem_sel  = vec_mem[base+4][0];
        master_except  = vec_mem[base+5][EXC_W-1:0];
        slave_except   = vec_mem[base+6][EXC_W-1:0];
        flush          = vec_mem[base+7][0];
        pend_we[0]     = vec_mem[base+9][0];
        pend_data[0]   = vec_mem[base+10];
        pend_fault[0]  = vec_mem[base+11][0];
        pend_rd[0]     = req_rd;
        // a flushed request never reaches write-back, so its causes vanish too.
        pend_exc[0]    = flush ? '0 : (master_except | slave_except);
    endtask

    // one clock of stimulus; the result of a request shows two falling edges later.
    task automatic next_cycle(input logic use_vec, input int base);
        @(negedge clk);
        check_outputs();
        pend_we[1]    = pend_we[0];
        pend_data[1]  = pend_data[0];
        pend_fault[1] = pend_fault[0];
        pend_rd[1]    = pend_rd[0];
        pend_exc[1]   = pend_exc[0];
        if (use_vec) begin
            drive_vector(base);
        end else begin
            drive_idle();
        end
    endtask

    initial begin
        int unsigned seed_out;
        int unsigned gap;
        int          idx;

        seed_out = $urandom(98);
        arst_n   = 1'b0;
        drive_idle();
        pend_we[1]    = 1'b0;
        pend_data[1]  = '0;
        pend_fault[1] = 1'b0;
        pend_rd[1]    = '0;
        pend_exc[1]   = '0;
        $readmemh("tests/mem_input.txt", vec_mem);

        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        check_value("wb_we", 32'(wb_we), 32'd0);
        check_value("wb_fault", 32'(wb_fault), 32'd0);
        check_value("wb_data", wb_data, 32'd0);

        idx = 0;
        while (idx < MAX_VEC && !$isunknown(vec_mem[idx*FIELDS])) begin
            // burst lines follow the previous request with no idle cycle.
            if (!vec_mem[idx*FIELDS+8][0]) begin
                gap = $urandom % 4;
                repeat (gap) next_cycle(1'b0, 0);
            end
            next_cycle(1'b1, idx*FIELDS);
            idx++;
        end
        if (idx == 0) begin
            errors++;
            $display("no vectors could be read from tests/mem_input.txt");
        end

        repeat (2) next_cycle(1'b0, 0);

        $display("vectors: %0d, checks: %0d, errors: %0d", idx, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
hdl/mem_op_pkg.sv
hdl/except_pkg.sv
hdl/mem_issue_stage.sv
hdl/mem_access.sv
hdl/data_sram.sv
hdl/wb_stage.sv
hdl/mem_subsys_top.sv
tests/tb_mem_subsys.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  - files:
      - hdl/mem_op_pkg.sv
      - hdl/except_pkg.sv
      - hdl/mem_issue_stage.sv
      - hdl/mem_access.sv
      - hdl/data_sram.sv
      - hdl/wb_stage.sv
      - hdl/mem_subsys_top.sv
  - target: test
    files:
      - tests/tb_mem_subsys.sv

// ==== tests/mem_input.txt ====
// op addr wdata rd sel(2 master, 1 slave) mexc sexc flush burst
// then expected: wb_we wb_data wb_fault
09 00000100 807fc312 00 2 00 00 0 0 0 00000000 0
01 00000100 00000000 01 2 00 00 0 0 1 807fc312 0
05 00000100 00000000 02 2 00 00 0 0 1 00000012 0
05 00000101 00000000 03 2 00 00 0 0 1 ffffffc3 0
05 00000102 00000000 04 2 00 00 0 0 1 0000007f 0
05 00000103 00000000 05 2 00 00 0 0 1 ffffff80 0
06 00000100 00000000 06 2 00 00 0 0 1 00000012 0
06 00000101 00000000 07 2 00 00 0 0 1 000000c3 0
06 00000102 00000000 08 2 00 00 0 0 1 0000007f 0
06 00000103 00000000 09 2 00 00 0 0 1 00000080 0
09 00000104 11223344 00 2 00 00 0 0 0 00000000 0
0d 00000104 0000a5f0 00 2 00 00 0 0 0 00000000 0
0e 00000107 000000ee 00 2 00 00 0 0 0 00000000 0
01 00000104 00000000 0a 2 00 00 0 0 1 ee22a5f0 0
03 00000104 00000000 0b 2 00 00 0 0 1 ffffa5f0 0
04 00000104 00000000 0c 2 00 00 0 0 1 0000a5f0 0
03 00000106 00000000 0d 2 00 00 0 0 1 ffffee22 0
04 00000106 00000000 0e 2 00 00 0 0 1 0000ee22 0
0d 00000106 00007abc 00 2 00 00 0 0 0 00000000 0
03 00000106 00000000 0f 2 00 00 0 0 1 00007abc 0
09 00000200 99887766 00 2 00 00 0 0 0 00000000 0
0a 00000200 a1b2c3d4 00 2 00 00 0 0 0 00000000 0
01 00000200 00000000 10 2 00 00 0 0 1 998877a1 0
0a 00000201 a1b2c3d4 00 2 00 00 0 0 0 00000000 0
01 00000200 00000000 11 2 00 00 0 0 1 9988a1b2 0
0a 00000202 a1b2c3d4 00 2 00 00 0 0 0 00000000 0
01 00000200 00000000 12 2 00 00 0 0 1 99a1b2c3 0
0a 00000203 a1b2c3d4 00 2 00 00 0 0 0 00000000 0
01 00000200 00000000 13 2 00 00 0 0 1 a1b2c3d4 0
09 00000204 99887766 00 2 00 00 0 0 0 00000000 0
0b 00000207 a1b2c3d4 00 2 00 00 0 0 0 00000000 0
01 00000204 00000000 14 2 00 00 0 0 1 d4887766 0
0b 00000206 a1b2c3d4 00 2 00 00 0 0 0 00000000 0
01 00000204 00000000 15 2 00 00 0 0 1 c3d47766 0
0b 00000205 a1b2c3d4 00 2 00 00 0 0 0 00000000 0
01 00000204 00000000 16 2 00 00 0 0 1 b2c3d466 0
0b 00000204 a1b2c3d4 00 2 00 00 0 0 0 00000000 0
01 00000204 00000000 17 2 00 00 0 0 1 a1b2c3d4 0
07 00000100 11223344 18 2 00 00 0 0 1 12223344 0
07 00000101 11223344 19 2 00 00 0 0 1 c3123344 0
07 00000102 11223344 1a 2 00 00 0 0 1 7fc31244 0
07 00000103 11223344 1b 2 00 00 0 0 1 807fc312 0
08 00000100 11223344 1c 2 00 00 0 0 1 807fc312 0
08 00000101 11223344 1d 2 00 00 0 0 1 11807fc3 0
08 00000102 11223344 1e 2 00 00 0 0 1 1122807f 0
08 00000103 11223344 1f 2 00 00 0 0 1 11223380 0
09 00000300 0badf00d 00 2 00 00 0 0 0 00000000 0
09 00000300 ffffffff 00 2 01 00 0 0 0 00000000 1
09 00000300 ffffffff 00 1 00 02 0 0 0 00000000 1
09 00000300 ffffffff 00 1 04 00 0 0 0 00000000 1
01 00000300 00000000 01 1 00 00 0 0 1 0badf00d 0
01 00000300 00000000 02 2 08 00 0 0 0 00000000 1
01 00000100 00000000 03 2 00 00 1 0 0 00000000 0
01 00000100 00000000 00 2 00 00 0 0 0 00000000 0
09 00000304 13579bdf 00 2 00 00 0 1 0 00000000 0
01 00000304 00000000 04 2 00 00 0 1 1 13579bdf 0
05 00000305 00000000 05 2 00 00 0 1 1 ffffff9b 0
04 00000306 00000000 06 2 00 00 0 1 1 00001357 0
